//--- narrator_pkg.sv
package narrator_pkg;

  // ==========================================================================
  // Widths and basic types
  // ==========================================================================

  // Flash word address width
  localparam int FLASH_ADDR_W = 23;

  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;

  // Signed 8-bit audio sample
  typedef logic signed [7:0] sample_t;

  // One flash word
  // Raw view for the bus, byte view for playback
  // Element 0 sits in bits 7..0 and plays first
  typedef union packed {
    logic [31:0]   raw;
    sample_t [3:0] bytes;
  } flash_word_u;

  // ==========================================================================
  // Flash port
  // ==========================================================================

  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_u readdata;
  } flash_rsp_t;

  // ==========================================================================
  // Phonemes and user controls
  // ==========================================================================

  // Inclusive word span of one phoneme
  typedef struct packed {
    flash_addr_t start_addr;
    flash_addr_t end_addr;
  } phoneme_span_t;

  // Speed strobes
  typedef struct packed {
    logic up;
    logic down;
    logic reset;
  } speed_cmd_t;

  localparam int PHONEME_COUNT = 8;

  // Contiguous spans of 1 to 4 words
  localparam phoneme_span_t PHONEME_TABLE [PHONEME_COUNT] = '{
    '{start_addr: 23'd0,  end_addr: 23'd1},
    '{start_addr: 23'd2,  end_addr: 23'd4},
    '{start_addr: 23'd5,  end_addr: 23'd8},
    '{start_addr: 23'd9,  end_addr: 23'd9},
    '{start_addr: 23'd10, end_addr: 23'd12},
    '{start_addr: 23'd13, end_addr: 23'd14},
    '{start_addr: 23'd15, end_addr: 23'd18},
    '{start_addr: 23'd19, end_addr: 23'd19}
  };

  // Keyboard codes for play and pause
  localparam logic [7:0] CHAR_PLAY_LC  = 8'h65;  // 'e'
  localparam logic [7:0] CHAR_PLAY_UC  = 8'h45;  // 'E'
  localparam logic [7:0] CHAR_PAUSE_LC = 8'h64;  // 'd'
  localparam logic [7:0] CHAR_PAUSE_UC = 8'h44;  // 'D'

endpackage

//--- sample_rate_timer.sv
`timescale 1ns/1ps

module sample_rate_timer #(
  parameter int DIV_W       = 16,
  parameter int DEFAULT_DIV = 6944,
  parameter int SPEED_STEP  = 100,
  parameter int MIN_DIV     = 3000,
  parameter int MAX_DIV     = 12000
) (
  input  logic                     CLK_50M,
  input  logic                     arst_n,
  input  narrator_pkg::speed_cmd_t speed,
  output logic                     tick
);

  // One extra bit so the step math never wraps
  localparam int EXT_W = DIV_W + 1;

  logic [DIV_W-1:0] div_q;
  logic [DIV_W-1:0] div_next;
  logic [DIV_W-1:0] cnt_q;
  logic [DIV_W-1:0] shrink;
  logic [EXT_W-1:0] div_ext;
  logic [EXT_W-1:0] faster;
  logic [EXT_W-1:0] slower;

  // ==========================================================================
  // Divisor update with clamping
  // ==========================================================================

  assign div_ext = {1'b0, div_q};
  assign faster  = div_ext - EXT_W'(SPEED_STEP);
  assign slower  = div_ext + EXT_W'(SPEED_STEP);

  // Reset wins over up, up wins over down
  always_comb
  begin
    div_next = div_q;
    if (speed.reset)
      div_next = DIV_W'(DEFAULT_DIV);
    else if (speed.up)
    begin
      // Shorter period means faster playback
      if (div_ext < EXT_W'(MIN_DIV + SPEED_STEP))
        div_next = DIV_W'(MIN_DIV);
      else
        div_next = faster[DIV_W-1:0];
    end
    else if (speed.down)
    begin
      if (slower > EXT_W'(MAX_DIV))
        div_next = DIV_W'(MAX_DIV);
      else
        div_next = slower[DIV_W-1:0];
    end
  end

  // ==========================================================================
  // Period counter
  // ==========================================================================

  // Amount a shorter divisor cuts from the running period
  assign shrink = div_q - div_next;

  // Last count of a period
  assign tick = (cnt_q == '0);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      div_q <= DIV_W'(DEFAULT_DIV);
      cnt_q <= DIV_W'(DEFAULT_DIV - 1);
    end
    else
    begin
      div_q <= div_next;
      if (tick)
        // New period always takes the latest divisor
        cnt_q <= div_next - 1'b1;
      else if (div_next < div_q)
      begin
        // Running period ends on the new divisor if that is sooner
        if (cnt_q > shrink)
          cnt_q <= cnt_q - shrink - 1'b1;
        else
          cnt_q <= '0;
      end
      else
        // Longer divisor waits for the next period
        cnt_q <= cnt_q - 1'b1;
    end
  end

  // Divisor stays inside the clamp window whatever strobes arrive
  a_div_range: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (div_q >= DIV_W'(MIN_DIV)) && (div_q <= DIV_W'(MAX_DIV)));

endmodule

//--- flash_word_reader.sv
`timescale 1ns/1ps

module flash_word_reader (
  input  logic                      CLK_50M,
  input  logic                      arst_n,
  input  logic                      fetch,
  input  narrator_pkg::flash_addr_t fetch_addr,
  output logic                      busy,
  output narrator_pkg::flash_req_t  flash_req,
  input  narrator_pkg::flash_rsp_t  flash_rsp,
  output narrator_pkg::flash_word_u word,
  output logic                      word_valid
);

  // Request phase, then data phase
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQ,
    RD_DATA
  } rd_state_e;

  rd_state_e                 state_q;
  narrator_pkg::flash_addr_t addr_q;

  // ==========================================================================
  // Read sequencing
  // ==========================================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q    <= RD_IDLE;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state_q)
        RD_IDLE:
        begin
          if (fetch)
            state_q <= RD_REQ;
        end
        RD_REQ:
        begin
          // Hold read until the flash accepts it
          if (!flash_rsp.waitrequest)
            state_q <= RD_DATA;
        end
        RD_DATA:
        begin
          // Variable latency until the word shows up
          if (flash_rsp.readdatavalid)
          begin
            state_q    <= RD_IDLE;
            word_valid <= 1'b1;
          end
        end
        default:
          state_q <= RD_IDLE;
      endcase
    end
  end

  // Address and returned word
  always_ff @(posedge CLK_50M)
  begin
    if (fetch && (state_q == RD_IDLE))
      addr_q <= fetch_addr;
    if ((state_q == RD_DATA) && flash_rsp.readdatavalid)
      word <= flash_rsp.readdata;
  end

  assign flash_req.read    = (state_q == RD_REQ);
  assign flash_req.address = addr_q;

  // Busy through the hand-off cycle so space is seen after the word lands
  assign busy = (state_q != RD_IDLE) || word_valid;

  // Address must not move while the flash stalls the read
  a_addr_hold: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_req.read && flash_rsp.waitrequest
    |=> flash_req.read && $stable(flash_req.address));

endmodule

//--- sample_unpacker.sv
`timescale 1ns/1ps

module sample_unpacker (
  input  logic                      CLK_50M,
  input  logic                      arst_n,
  input  narrator_pkg::flash_word_u word,
  input  logic                      word_valid,
  input  logic                      take,
  output narrator_pkg::sample_t     cur_sample,
  output logic                      has_sample,
  output logic                      has_space,
  input  logic                      flush
);

  narrator_pkg::flash_word_u cur_word;
  narrator_pkg::flash_word_u spare_word;
  logic                      cur_valid;
  logic                      spare_valid;
  logic [1:0]                byte_idx;
  logic                      cur_free;
  logic                      cur_load;
  logic                      spare_load;

  // Current slot empties on the fourth take
  assign cur_free = !cur_valid || (take && (byte_idx == 2'd3));

  // Spare moves up first, otherwise a fresh word goes straight in
  assign cur_load   = cur_free && (spare_valid || word_valid);
  assign spare_load = word_valid && !(cur_free && !spare_valid);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cur_valid   <= 1'b0;
      spare_valid <= 1'b0;
      byte_idx    <= 2'd0;
    end
    else if (flush)
    begin
      cur_valid   <= 1'b0;
      spare_valid <= 1'b0;
      byte_idx    <= 2'd0;
    end
    else
    begin
      if (cur_free)
      begin
        cur_valid <= spare_valid || word_valid;
        byte_idx  <= 2'd0;
      end
      else if (take)
        byte_idx <= byte_idx + 2'd1;
      if (spare_load)
        spare_valid <= 1'b1;
      else if (cur_free)
        spare_valid <= 1'b0;
    end
  end

  // Word storage
  always_ff @(posedge CLK_50M)
  begin
    if (cur_load)
      cur_word <= spare_valid ? spare_word : word;
    if (spare_load)
      spare_word <= word;
  end

  // Lowest byte plays first
  assign cur_sample = cur_word.bytes[byte_idx];
  assign has_sample = cur_valid;
  assign has_space  = !spare_valid;

  // Fetch pacing upstream keeps the buffer from overflowing
  a_no_overflow: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    word_valid |-> has_space);

  a_no_underflow: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    take |-> has_sample);

endmodule

//--- narrator_fsm.sv
`timescale 1ns/1ps

module narrator_fsm (
  input  logic                      CLK_50M,
  input  logic                      arst_n,
  input  logic [7:0]                phoneme_sel,
  input  logic                      phoneme_start,
  input  logic [7:0]                kbd_ascii,
  input  logic                      kbd_valid,
  input  logic                      tick,
  input  logic                      has_sample,
  input  logic                      has_space,
  input  narrator_pkg::sample_t     cur_sample,
  input  logic                      reader_busy,
  output logic                      fetch,
  output narrator_pkg::flash_addr_t fetch_addr,
  output logic                      take,
  output logic                      flush,
  output narrator_pkg::sample_t     sample,
  output logic                      sample_valid,
  output logic                      phoneme_done,
  output logic                      playing
);

  localparam int SEL_W = $clog2(narrator_pkg::PHONEME_COUNT);
  localparam int CNT_W = narrator_pkg::FLASH_ADDR_W + 2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCHING,
    ST_DRAINING
  } nar_state_e;

  nar_state_e                  state_q;
  narrator_pkg::flash_addr_t   addr_q;
  narrator_pkg::flash_addr_t   end_q;
  narrator_pkg::flash_addr_t   span_len;
  narrator_pkg::phoneme_span_t span;
  logic [CNT_W-1:0]            remaining_q;
  logic                        sel_ok;
  logic                        last_q;

  // ==========================================================================
  // Phoneme lookup
  // ==========================================================================

  // Indices past the table are ignored
  assign sel_ok   = (phoneme_sel < 8'(narrator_pkg::PHONEME_COUNT));
  assign span     = narrator_pkg::PHONEME_TABLE[phoneme_sel[SEL_W-1:0]];
  assign span_len = span.end_addr - span.start_addr + 1'b1;

  // ==========================================================================
  // Fetch and playback control
  // ==========================================================================

  // One read at a time, only while the buffer can take a word
  assign fetch      = (state_q == ST_FETCHING) && has_space && !reader_busy;
  assign fetch_addr = addr_q;

  // Ticks while paused or starved are dropped
  assign take = (state_q != ST_IDLE) && tick && playing && has_sample;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q     <= ST_IDLE;
      addr_q      <= '0;
      end_q       <= '0;
      remaining_q <= '0;
      last_q      <= 1'b0;
    end
    else
    begin
      last_q <= take && (remaining_q == CNT_W'(1));
      case (state_q)
        ST_IDLE:
        begin
          // Starts during playback never reach here
          if (phoneme_start && sel_ok)
          begin
            addr_q      <= span.start_addr;
            end_q       <= span.end_addr;
            remaining_q <= {span_len, 2'b00};
            state_q     <= ST_FETCHING;
          end
        end
        ST_FETCHING:
        begin
          if (fetch)
          begin
            if (addr_q == end_q)
              state_q <= ST_DRAINING;
            else
              addr_q <= addr_q + 1'b1;
          end
        end
        ST_DRAINING:
        begin
          // All words requested, wait for the last sample
          if (take && (remaining_q == CNT_W'(1)))
            state_q <= ST_IDLE;
        end
        default:
          state_q <= ST_IDLE;
      endcase
      if (take)
        remaining_q <= remaining_q - 1'b1;
    end
  end

  // ==========================================================================
  // Output sample and completion
  // ==========================================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sample       <= '0;
      sample_valid <= 1'b0;
      phoneme_done <= 1'b0;
    end
    else
    begin
      sample_valid <= take;
      // Done trails the last sample by one cycle
      phoneme_done <= last_q;
      if (take)
        sample <= cur_sample;
    end
  end

  // Clear leftovers once the span has played out
  assign flush = last_q;

  // ==========================================================================
  // Play and pause keys
  // ==========================================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      playing <= 1'b0;
    else if (kbd_valid)
    begin
      case (kbd_ascii)
        narrator_pkg::CHAR_PLAY_LC,
        narrator_pkg::CHAR_PLAY_UC:
          playing <= 1'b1;
        narrator_pkg::CHAR_PAUSE_LC,
        narrator_pkg::CHAR_PAUSE_UC:
          playing <= 1'b0;
        // Other keys keep the current state
        default:
          playing <= playing;
      endcase
    end
  end

  // Each fetch finds the reader free and occupies it next cycle
  a_fetch_idle: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    fetch |-> !reader_busy ##1 reader_busy);

endmodule

//--- narrator_top.sv
`timescale 1ns/1ps

module narrator_top #(
  parameter int DIV_W       = 16,
  parameter int DEFAULT_DIV = 6944,
  parameter int SPEED_STEP  = 100,
  parameter int MIN_DIV     = 3000,
  parameter int MAX_DIV     = 12000
) (
  input  logic                     CLK_50M,
  input  logic                     arst_n,
  input  logic [7:0]               phoneme_sel,
  input  logic                     phoneme_start,
  input  logic [7:0]               kbd_ascii,
  input  logic                     kbd_valid,
  input  narrator_pkg::speed_cmd_t speed,
  output narrator_pkg::flash_req_t flash_req,
  input  narrator_pkg::flash_rsp_t flash_rsp,
  output narrator_pkg::sample_t    sample,
  output logic                     sample_valid,
  output logic                     phoneme_done,
  output logic                     playing
);

  // ==========================================================================
  // Internal links
  // ==========================================================================

  logic                      tick;
  logic                      fetch;
  narrator_pkg::flash_addr_t fetch_addr;
  logic                      reader_busy;
  narrator_pkg::flash_word_u word;
  logic                      word_valid;
  logic                      take;
  logic                      flush;
  narrator_pkg::sample_t     cur_sample;
  logic                      has_sample;
  logic                      has_space;

  // Sample tick from the adjustable divider
  sample_rate_timer #(
    .DIV_W       (DIV_W),
    .DEFAULT_DIV (DEFAULT_DIV),
    .SPEED_STEP  (SPEED_STEP),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV)
  ) u_timer (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .speed   (speed),
    .tick    (tick)
  );

  narrator_fsm u_fsm (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .phoneme_sel   (phoneme_sel),
    .phoneme_start (phoneme_start),
    .kbd_ascii     (kbd_ascii),
    .kbd_valid     (kbd_valid),
    .tick          (tick),
    .has_sample    (has_sample),
    .has_space     (has_space),
    .cur_sample    (cur_sample),
    .reader_busy   (reader_busy),
    .fetch         (fetch),
    .fetch_addr    (fetch_addr),
    .take          (take),
    .flush         (flush),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .phoneme_done  (phoneme_done),
    .playing       (playing)
  );

  // Flash side
  flash_word_reader u_reader (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .fetch      (fetch),
    .fetch_addr (fetch_addr),
    .busy       (reader_busy),
    .flash_req  (flash_req),
    .flash_rsp  (flash_rsp),
    .word       (word),
    .word_valid (word_valid)
  );

  sample_unpacker u_unpacker (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .word       (word),
    .word_valid (word_valid),
    .take       (take),
    .cur_sample (cur_sample),
    .has_sample (has_sample),
    .has_space  (has_space),
    .flush      (flush)
  );

endmodule

//--- flash_model.sv
`timescale 1ns/1ps

module flash_model (
  input  logic                     CLK_50M,
  input  logic                     arst_n,
  input  narrator_pkg::flash_req_t flash_req,
  output narrator_pkg::flash_rsp_t flash_rsp
);

  logic [31:0]               lcg_q;
  logic [31:0]               next_lcg;
  logic [1:0]                wait_left;
  logic [2:0]                lat_left;
  logic                      busy;
  logic                      rdv_q;
  narrator_pkg::flash_addr_t addr_q;
  narrator_pkg::flash_word_u data_q;

  // LCG step for wait states and latency
  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Byte k of word a holds the low 8 bits of 4a+k
  function automatic narrator_pkg::flash_word_u word_at(input narrator_pkg::flash_addr_t a);
    narrator_pkg::flash_word_u w;
    for (int k = 0; k < 4; k++)
      w.bytes[k] = 8'({a, 2'b00} + 25'(k));
    return w;
  endfunction

  assign next_lcg = lcg_step(lcg_q);

  // Stall while wait states remain or a read is still in flight
  assign flash_rsp.waitrequest   = flash_req.read && (busy || (wait_left != 2'd0));
  assign flash_rsp.readdatavalid = rdv_q;
  assign flash_rsp.readdata      = data_q;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      lcg_q     <= 32'd54;
      wait_left <= 2'd0;
      lat_left  <= 3'd0;
      busy      <= 1'b0;
      rdv_q     <= 1'b0;
      addr_q    <= '0;
      data_q    <= '0;
    end
    else
    begin
      rdv_q <= 1'b0;
      if (busy)
      begin
        // Latency countdown, word comes out on the last step
        if (lat_left == 3'd1)
        begin
          rdv_q  <= 1'b1;
          data_q <= word_at(addr_q);
          busy   <= 1'b0;
        end
        else
          lat_left <= lat_left - 3'd1;
      end
      else if (flash_req.read)
      begin
        if (wait_left != 2'd0)
          wait_left <= wait_left - 2'd1;
        else
        begin
          // Accepted; draw latency 1..6 and the next wait count 0..3
          addr_q    <= flash_req.address;
          busy      <= 1'b1;
          lat_left  <= (next_lcg[18:16] % 3'd6) + 3'd1;
          wait_left <= next_lcg[25:24];
          lcg_q     <= next_lcg;
        end
      end
    end
  end

endmodule

//--- tb_narrator.sv
`timescale 1ns/1ps

module tb_narrator;

  localparam int WAIT_LIMIT = 5000;
  localparam int SETTLE     = 100;

  logic                     CLK_50M;
  logic                     arst_n;
  logic [7:0]               phoneme_sel;
  logic                     phoneme_start;
  logic [7:0]               kbd_ascii;
  logic                     kbd_valid;
  narrator_pkg::speed_cmd_t speed;
  narrator_pkg::flash_req_t flash_req;
  narrator_pkg::flash_rsp_t flash_rsp;
  narrator_pkg::sample_t    sample;
  logic                     sample_valid;
  logic                     phoneme_done;
  logic                     playing;

  // Capture of the current phoneme
  int                        cycle = 0;
  logic [7:0]                sample_q[$];
  int                        sample_cyc_q[$];
  int                        done_cyc_q[$];
  narrator_pkg::flash_addr_t addr_q[$];
  logic                      stall_seen = 1'b0;
  narrator_pkg::flash_addr_t stall_addr;
  logic [31:0]               lcg_state = 32'd54;

  narrator_top #(
    .DIV_W       (16),
    .DEFAULT_DIV (40),
    .SPEED_STEP  (8),
    .MIN_DIV     (24),
    .MAX_DIV     (64)
  ) dut (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .phoneme_sel   (phoneme_sel),
    .phoneme_start (phoneme_start),
    .kbd_ascii     (kbd_ascii),
    .kbd_valid     (kbd_valid),
    .speed         (speed),
    .flash_req     (flash_req),
    .flash_rsp     (flash_rsp),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .phoneme_done  (phoneme_done),
    .playing       (playing)
  );

  flash_model u_flash (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  // 50 MHz
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ==========================================================================
  // Checking helpers
  // ==========================================================================

  task automatic stop_failed();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error: %s", why);
    stop_failed();
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Expected flash byte k of word a
  function automatic logic [7:0] expected_byte(input int word_addr, input int k);
    return 8'((4 * word_addr + k) % 256);
  endfunction

  // Monitor on the rising edge, values are those of the ending cycle
  always @(posedge CLK_50M)
  begin
    if (arst_n)
    begin
      cycle++;
      // A stalled read must be held with the same address
      if (stall_seen)
      begin
        compare("flash_req.read", 32'(flash_req.read), 32'd1);
        compare("flash_req.address", 32'(flash_req.address), 32'(stall_addr));
      end
      stall_seen = flash_req.read && flash_rsp.waitrequest;
      stall_addr = flash_req.address;
      if (flash_req.read && !flash_rsp.waitrequest)
        addr_q.push_back(flash_req.address);
      if (sample_valid)
      begin
        sample_q.push_back(sample);
        sample_cyc_q.push_back(cycle);
      end
      if (phoneme_done)
        done_cyc_q.push_back(cycle);
    end
    else
      stall_seen = 1'b0;
  end

  // ==========================================================================
  // Stimulus helpers
  // ==========================================================================

  task automatic clear_capture();
    sample_q.delete();
    sample_cyc_q.delete();
    done_cyc_q.delete();
    addr_q.delete();
  endtask

  task automatic issue_start(input int idx);
    @(negedge CLK_50M);
    phoneme_sel   = 8'(idx);
    phoneme_start = 1'b1;
    @(negedge CLK_50M);
    phoneme_start = 1'b0;
  endtask

  task automatic press_key(input logic [7:0] code);
    @(negedge CLK_50M);
    kbd_ascii = code;
    kbd_valid = 1'b1;
    @(negedge CLK_50M);
    kbd_valid = 1'b0;
  endtask

  task automatic pulse_speed(input logic up, input logic down, input logic rst);
    @(negedge CLK_50M);
    speed.up    = up;
    speed.down  = down;
    speed.reset = rst;
    @(negedge CLK_50M);
    speed = '0;
  endtask

  task automatic wait_sample_count(input int n, input string what);
    int waited;
    waited = 0;
    while (sample_q.size() < n)
    begin
      if (waited == WAIT_LIMIT)
        abort_run($sformatf("no sample_valid seen in time while waiting for %s", what));
      else
      begin
        @(negedge CLK_50M);
        waited++;
      end
    end
  endtask

  task automatic wait_done(input string what);
    int waited;
    waited = 0;
    while (done_cyc_q.size() < 1)
    begin
      if (waited == WAIT_LIMIT)
        abort_run($sformatf("phoneme_done never pulsed during %s", what));
      else
      begin
        @(negedge CLK_50M);
        waited++;
      end
    end
    // Room for a stray second pulse or extra samples
    repeat (SETTLE) @(negedge CLK_50M);
  endtask

  // Samples, flash addresses and done pulse of one span
  task automatic check_span(input int idx);
    narrator_pkg::phoneme_span_t span;
    int first;
    int words;
    int n;
    span  = narrator_pkg::PHONEME_TABLE[idx];
    first = int'(span.start_addr);
    words = int'(span.end_addr) - first + 1;
    n     = 4 * words;
    compare("sample count", 32'(sample_q.size()), 32'(n));
    compare("flash read count", 32'(addr_q.size()), 32'(words));
    for (int i = 0; i < words; i++)
      compare("flash_req.address", 32'(addr_q[i]), 32'(first + i));
    for (int i = 0; i < n; i++)
      compare("sample", 32'(sample_q[i]), 32'(expected_byte(first + i / 4, i % 4)));
    compare("phoneme_done count", 32'(done_cyc_q.size()), 32'd1);
    compare("phoneme_done cycle", 32'(done_cyc_q[0]), 32'(sample_cyc_q[n-1] + 1));
  endtask

  // Intervals between samples first..first+count
  task automatic check_spacing(input int first, input int count, input int div);
    wait_sample_count(first + count + 1, "spacing samples");
    for (int i = first; i < first + count; i++)
      compare("sample_valid spacing", 32'(sample_cyc_q[i+1] - sample_cyc_q[i]), 32'(div));
  endtask

  // Whole phoneme 6 at a divisor set while idle
  task automatic spacing_run(input int div);
    clear_capture();
    issue_start(6);
    check_spacing(1, 3, div);
    wait_done("spacing run");
    check_span(6);
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================

  task automatic check_reset_state();
    compare("sample_valid", 32'(sample_valid), 32'd0);
    compare("phoneme_done", 32'(phoneme_done), 32'd0);
    compare("playing", 32'(playing), 32'd0);
    compare("flash_req.read", 32'(flash_req.read), 32'd0);
    compare("sample", 32'(8'(sample)), 32'd0);
  endtask

  task automatic play_one_phoneme();
    press_key("e");
    compare("playing", 32'(playing), 32'd1);
    clear_capture();
    issue_start(2);
    wait_done("phoneme 2");
    check_span(2);
  endtask

  task automatic measure_speed_steps();
    int base;
    clear_capture();
    issue_start(6);
    check_spacing(0, 2, 40);
    // Mid-phoneme changes, first period after each one skipped
    pulse_speed(1'b1, 1'b0, 1'b0);
    base = sample_q.size();
    check_spacing(base, 2, 32);
    pulse_speed(1'b0, 1'b1, 1'b0);
    base = sample_q.size();
    check_spacing(base, 2, 40);
    wait_done("speed steps");
    check_span(6);
    // Clamp at the slow end
    repeat (5) pulse_speed(1'b0, 1'b1, 1'b0);
    spacing_run(64);
    // Clamp at the fast end
    repeat (7) pulse_speed(1'b1, 1'b0, 1'b0);
    spacing_run(24);
    pulse_speed(1'b0, 1'b0, 1'b1);
    spacing_run(40);
  endtask

  task automatic pause_and_resume();
    int held;
    clear_capture();
    issue_start(6);
    wait_sample_count(5, "samples before pause");
    press_key("D");
    compare("playing", 32'(playing), 32'd0);
    // One tick may still be in flight
    repeat (2) @(negedge CLK_50M);
    held = sample_q.size();
    if (held >= 16)
      abort_run("the phoneme ended before the pause took effect");
    repeat (160) @(negedge CLK_50M);
    compare("sample count while paused", 32'(sample_q.size()), 32'(held));
    // Unknown key leaves the state alone
    press_key("x");
    compare("playing", 32'(playing), 32'd0);
    repeat (80) @(negedge CLK_50M);
    compare("sample count after other key", 32'(sample_q.size()), 32'(held));
    press_key("E");
    compare("playing", 32'(playing), 32'd1);
    wait_done("resumed phoneme");
    check_span(6);
  endtask

  task automatic play_back_to_back();
    int idx;
    for (int n = 0; n < 5; n++)
    begin
      lcg_state = lcg_step(lcg_state);
      idx = int'(lcg_state[18:16]);
      clear_capture();
      issue_start(idx);
      wait_sample_count(1, "first sample of a chained phoneme");
      // Busy, so this start is dropped
      issue_start((idx + 3) % narrator_pkg::PHONEME_COUNT);
      wait_done("chained phoneme");
      check_span(idx);
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial
  begin
    arst_n        = 1'b0;
    phoneme_sel   = 8'd0;
    phoneme_start = 1'b0;
    kbd_ascii     = 8'd0;
    kbd_valid     = 1'b0;
    speed         = '0;
    repeat (5) @(negedge CLK_50M);
    arst_n = 1'b1;
    @(negedge CLK_50M);
    check_reset_state();
    play_one_phoneme();
    measure_speed_steps();
    pause_and_resume();
    play_back_to_back();
    $display("** PASS **");
    $finish;
  end

endmodule

//--- sim.f
narrator_pkg.sv
sample_rate_timer.sv
flash_word_reader.sv
sample_unpacker.sv
narrator_fsm.sv
narrator_top.sv
flash_model.sv
tb_narrator.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_narrator
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
